/* logic/ycr_router_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Memory router shared definitions
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ycr_router_pkg;

    // Requester count: two cores, imem and dmem port each
    localparam int unsigned n_req     = 4;
    localparam int unsigned req_idx_w = $clog2(n_req);

    // Field widths
    localparam int unsigned tid_w   = 3;
    localparam int unsigned awidth  = 32;
    localparam int unsigned dwidth  = 32;
    localparam int unsigned bsize   = 8;
    localparam int unsigned width_w = 2;

    // Target response codes, rdy_lok flags the last beat of a burst
    typedef enum logic [1:0] {
        resp_notrdy = 2'd0,
        resp_rdy_ok = 2'd1,
        resp_rdy_er = 2'd2,
        resp_rdy_lok = 2'd3
    } mem_resp_e;

    typedef logic [req_idx_w-1:0] req_idx_t;

    // Request payload, 75 bits
    typedef struct packed {
        logic               cmd;
        logic [width_w-1:0] width;
        logic [awidth-1:0]  addr;
        logic [bsize-1:0]   bl;
        logic [dwidth-1:0]  wdata;
    } mem_req_t;

endpackage : ycr_router_pkg

`default_nettype wire

/* logic/router_grant_if.sv */
//////////////////////////////////////////////////////////////////////
// Grant and target status bundle
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface router_grant_if;

    // Grant from the arbiter
    logic                     gnt_vld;
    ycr_router_pkg::req_idx_t gnt_idx;

    // Target status back to the arbiter
    logic                     tgt_req_ack;
    logic                     tgt_lack;

    modport arb       (output gnt_vld, gnt_idx, input tgt_req_ack, tgt_lack);
    modport req_path  (input gnt_vld, gnt_idx);
    modport resp_path (input gnt_vld, gnt_idx, output tgt_req_ack, tgt_lack);

endinterface : router_grant_if

`default_nettype wire

/* logic/router_rr_pointer.sv */
//////////////////////////////////////////////////////////////////////
// Round-robin priority pointer
//////////////////////////////////////////////////////////////////////

`default_nettype none

module router_rr_pointer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ycr_router_pkg::n_req-1:0]  req_hit,
    input  logic                              advance,
    output ycr_router_pkg::req_idx_t          winner,
    output logic                              any_hit
);
    import ycr_router_pkg::*;

    // Highest priority position
    req_idx_t ptr;

    assign any_hit = |req_hit;

    // Search from ptr upward, wrapping at n_req
    always_comb begin
        int unsigned cand;
        logic        found;
        found  = 1'b0;
        winner = ptr;
        for (int unsigned off = 0; off < n_req; off++) begin
            cand = (32'(ptr) + off) % n_req;
            if (!found && req_hit[cand]) begin
                found  = 1'b1;
                winner = req_idx_t'(cand);
            end
        end
    end

    // Next search starts just past the last winner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance) begin
            ptr <= (winner == req_idx_t'(n_req - 1)) ? '0 : winner + 1'b1;
        end
    end

endmodule : router_rr_pointer

`default_nettype wire

/* logic/router_arb_fsm.sv */
//////////////////////////////////////////////////////////////////////
// Grant FSM with burst lock
//////////////////////////////////////////////////////////////////////

`default_nettype none

module router_arb_fsm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ycr_router_pkg::n_req-1:0]  req_hit,
    router_grant_if.arb                       grant
);
    import ycr_router_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_burst
    } arb_state_e;

    arb_state_e state;
    logic       gnt_vld;
    req_idx_t   gnt_idx;
    req_idx_t   winner;
    logic       any_hit;
    logic       advance;

    router_rr_pointer u_rr_pointer (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_hit (req_hit),
        .advance (advance),
        .winner  (winner),
        .any_hit (any_hit)
    );

    // One pointer step per new grant
    assign advance = (state == st_idle) && any_hit;

    //////////////////////////////////////////////////////////////////////
    // State and grant registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            gnt_vld <= 1'b0;
            gnt_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (any_hit) begin
                        gnt_idx <= winner;
                        gnt_vld <= 1'b1;
                        state   <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    // Last beat may come with the accept itself
                    if (grant.tgt_lack) begin
                        gnt_vld <= 1'b0;
                        state   <= st_idle;
                    end else if (grant.tgt_req_ack) begin
                        state <= st_burst;
                    end
                end
                st_burst: begin
                    if (grant.tgt_lack) begin
                        gnt_vld <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign grant.gnt_vld = gnt_vld;
    assign grant.gnt_idx = gnt_idx;

endmodule : router_arb_fsm

`default_nettype wire

/* logic/router_req_select.sv */
//////////////////////////////////////////////////////////////////////
// Target id filter and request mux
//////////////////////////////////////////////////////////////////////

`default_nettype none

module router_req_select (
    input  logic [ycr_router_pkg::tid_w-1:0]                             target_id,
    input  logic [ycr_router_pkg::n_req-1:0]                             req,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::tid_w-1:0] tid,
    input  ycr_router_pkg::mem_req_t [ycr_router_pkg::n_req-1:0]         req_pl,
    router_grant_if.req_path                                              grant,
    output logic [ycr_router_pkg::n_req-1:0]                             req_hit,
    output logic                                                          core_req,
    output ycr_router_pkg::mem_req_t                                      core_pl
);
    import ycr_router_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Request filter
    //////////////////////////////////////////////////////////////////////

    // Only requests aimed at this target take part
    always_comb begin
        for (int unsigned i = 0; i < n_req; i++) begin
            req_hit[i] = req[i] && (tid[i] == target_id);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Payload mux
    //////////////////////////////////////////////////////////////////////

    // Granted requester onto the target port, zero when idle
    always_comb begin
        if (grant.gnt_vld) begin
            core_req = req_hit[grant.gnt_idx];
            core_pl  = req_pl[grant.gnt_idx];
        end else begin
            core_req = 1'b0;
            core_pl  = '0;
        end
    end

endmodule : router_req_select

`default_nettype wire

/* logic/router_resp_route.sv */
//////////////////////////////////////////////////////////////////////
// Response demux
//////////////////////////////////////////////////////////////////////

`default_nettype none

module router_resp_route (
    input  logic                                                          core_req_ack,
    input  logic [ycr_router_pkg::dwidth-1:0]                             core_rdata,
    input  ycr_router_pkg::mem_resp_e                                     core_resp,
    router_grant_if.resp_path                                             grant,
    output logic [ycr_router_pkg::n_req-1:0]                              req_ack,
    output logic [ycr_router_pkg::n_req-1:0]                              lack,
    output logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::dwidth-1:0] rdata,
    output logic [ycr_router_pkg::n_req-1:0][1:0]                         resp
);
    import ycr_router_pkg::*;

    logic last_beat;

    // Last beat of burst ends the grant
    assign last_beat         = (core_resp == resp_rdy_lok);
    assign grant.tgt_lack    = last_beat;
    assign grant.tgt_req_ack = core_req_ack;

    // Only the granted requester sees the target
    // Requesters do not decode last ack, so resp[1] is held low
    always_comb begin
        logic sel;
        for (int unsigned i = 0; i < n_req; i++) begin
            sel        = grant.gnt_vld && (grant.gnt_idx == req_idx_t'(i));
            req_ack[i] = sel && core_req_ack;
            lack[i]    = sel && last_beat;
            rdata[i]   = sel ? core_rdata : '0;
            resp[i]    = sel ? {1'b0, core_resp[0]} : 2'b00;
        end
    end

endmodule : router_resp_route

`default_nettype wire

/* logic/ycr_mem_router.sv */
//////////////////////////////////////////////////////////////////////
// Memory request router top
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ycr_mem_router (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic [ycr_router_pkg::tid_w-1:0]                              target_id,

    // Requester side, one slice per requester
    input  logic [ycr_router_pkg::n_req-1:0]                              req,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::tid_w-1:0]   tid,
    input  logic [ycr_router_pkg::n_req-1:0]                              cmd,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::width_w-1:0] width,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::awidth-1:0]  addr,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::bsize-1:0]   bl,
    input  logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::dwidth-1:0]  wdata,
    output logic [ycr_router_pkg::n_req-1:0]                              req_ack,
    output logic [ycr_router_pkg::n_req-1:0]                              lack,
    output logic [ycr_router_pkg::n_req-1:0][ycr_router_pkg::dwidth-1:0]  rdata,
    output logic [ycr_router_pkg::n_req-1:0][1:0]                         resp,

    // Target side
    output logic                                                          core_req,
    output logic                                                          core_cmd,
    output logic [ycr_router_pkg::width_w-1:0]                            core_width,
    output logic [ycr_router_pkg::awidth-1:0]                             core_addr,
    output logic [ycr_router_pkg::bsize-1:0]                              core_bl,
    output logic [ycr_router_pkg::dwidth-1:0]                             core_wdata,
    input  logic                                                          core_req_ack,
    input  logic [ycr_router_pkg::dwidth-1:0]                             core_rdata,
    input  logic [1:0]                                                    core_resp
);
    import ycr_router_pkg::*;

    mem_req_t [n_req-1:0] req_pl;
    mem_req_t             core_pl;
    logic [n_req-1:0]     req_hit;
    mem_resp_e            core_resp_e;

    router_grant_if u_grant_if ();

    // Pack per-field inputs into payload structs
    always_comb begin
        for (int unsigned i = 0; i < n_req; i++) begin
            req_pl[i].cmd   = cmd[i];
            req_pl[i].width = width[i];
            req_pl[i].addr  = addr[i];
            req_pl[i].bl    = bl[i];
            req_pl[i].wdata = wdata[i];
        end
    end

    assign core_resp_e = mem_resp_e'(core_resp);

    //////////////////////////////////////////////////////////////////////
    // Arbiter, request path, response path
    //////////////////////////////////////////////////////////////////////
    router_arb_fsm u_arb_fsm (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_hit (req_hit),
        .grant   (u_grant_if.arb)
    );

    router_req_select u_req_select (
        .target_id (target_id),
        .req       (req),
        .tid       (tid),
        .req_pl    (req_pl),
        .grant     (u_grant_if.req_path),
        .req_hit   (req_hit),
        .core_req  (core_req),
        .core_pl   (core_pl)
    );

    router_resp_route u_resp_route (
        .core_req_ack (core_req_ack),
        .core_rdata   (core_rdata),
        .core_resp    (core_resp_e),
        .grant        (u_grant_if.resp_path),
        .req_ack      (req_ack),
        .lack         (lack),
        .rdata        (rdata),
        .resp         (resp)
    );

    // Muxed payload out to the target pins
    assign core_cmd   = core_pl.cmd;
    assign core_width = core_pl.width;
    assign core_addr  = core_pl.addr;
    assign core_bl    = core_pl.bl;
    assign core_wdata = core_pl.wdata;

endmodule : ycr_mem_router

`default_nettype wire

/* dv/router_assert.sv */
//////////////////////////////////////////////////////////////////////
// Router grant checks
//////////////////////////////////////////////////////////////////////

`default_nettype none

module router_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             gnt_vld,
    input ycr_router_pkg::req_idx_t         gnt_idx,
    input logic                             core_req,
    input logic [ycr_router_pkg::n_req-1:0] req_ack
);
    import ycr_router_pkg::*;

    // Target port only driven under a grant
    core_req_needs_grant: assert property (
        @(posedge clk) disable iff (!rst_n) core_req |-> gnt_vld
    ) else $error("core_req high without a grant");

    // Accept reaches one requester at most
    single_req_ack: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(req_ack)
    ) else $error("req_ack high on more than one requester");

    // Burst lock, granted index frozen
    gnt_idx_stable: assert property (
        @(posedge clk) disable iff (!rst_n) gnt_vld && $past(gnt_vld) |-> $stable(gnt_idx)
    ) else $error("gnt_idx changed while the grant was held");

endmodule : router_assert

bind ycr_mem_router router_assert u_router_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .gnt_vld  (u_grant_if.gnt_vld),
    .gnt_idx  (u_grant_if.gnt_idx),
    .core_req (core_req),
    .req_ack  (req_ack)
);

`default_nettype wire

/* dv/tb_ycr_mem_router.sv */
//////////////////////////////////////////////////////////////////////
// Memory router testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_ycr_mem_router;
    import ycr_router_pkg::*;

    localparam int unsigned clk_period   = 4;
    // Worst burst is grant wait, 4 stall cycles, accept, 4 beats and idle
    localparam int unsigned burst_cycles = 24;
    localparam int unsigned n_bursts     = 12;
    localparam int unsigned limit_time   = (n_bursts * burst_cycles + 64) * clk_period;

    logic                          clk;
    logic                          rst_n;
    logic [tid_w-1:0]              target_id;
    logic [n_req-1:0]              req, cmd, req_ack, lack;
    logic [n_req-1:0][tid_w-1:0]   tid;
    logic [n_req-1:0][width_w-1:0] width;
    logic [n_req-1:0][awidth-1:0]  addr;
    logic [n_req-1:0][bsize-1:0]   bl;
    logic [n_req-1:0][dwidth-1:0]  wdata, rdata;
    logic [n_req-1:0][1:0]         resp;
    logic                          core_req, core_cmd, core_req_ack;
    logic [width_w-1:0]            core_width;
    logic [awidth-1:0]             core_addr;
    logic [bsize-1:0]              core_bl;
    logic [dwidth-1:0]             core_wdata, core_rdata;
    logic [1:0]                    core_resp;

    integer      seed;
    int unsigned n_pass, n_fail, n_tests, fail_mark;
    // Payload each requester currently offers
    mem_req_t    pl [n_req];

    ycr_mem_router u_ycr_mem_router (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_req(input string what, input mem_req_t got, input mem_req_t exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input mem_resp_e got, input mem_resp_e exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(input string what, input req_idx_t got, input req_idx_t exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input string what, input logic [dwidth-1:0] got,
                              input logic [dwidth-1:0] exp);
        if (got === exp) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        n_tests++;
        if (n_fail == fail_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, n_fail - fail_mark);
        end
        fail_mark = n_fail;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Requester and target models
    //////////////////////////////////////////////////////////////////////
    function automatic mem_req_t core_payload();
        return '{core_cmd, core_width, core_addr, core_bl, core_wdata};
    endfunction

    // Lowest requester index holding req_ack
    function automatic req_idx_t ack_owner();
        req_idx_t who;
        who = '0;
        for (int i = n_req - 1; i >= 0; i--) begin
            if (req_ack[i]) who = req_idx_t'(i);
        end
        return who;
    endfunction

    task automatic do_reset();
        rst_n        = 1'b0;
        req          = '0;
        core_req_ack = 1'b0;
        core_resp    = 2'b00;
        core_rdata   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Short bursts of at most four beats
    task automatic new_payload(input int unsigned i, input logic is_wr);
        pl[i].cmd   = is_wr;
        pl[i].width = width_w'($random(seed));
        pl[i].addr  = $random(seed);
        pl[i].bl    = bsize'($random(seed)) & 8'h03;
        pl[i].wdata = $random(seed);
    endtask

    task automatic drive_req(input int unsigned i, input logic [tid_w-1:0] t);
        tid[i]   = t;
        cmd[i]   = pl[i].cmd;
        width[i] = pl[i].width;
        addr[i]  = pl[i].addr;
        bl[i]    = pl[i].bl;
        wdata[i] = pl[i].wdata;
        req[i]   = 1'b1;
    endtask

    task automatic wait_core_req(output bit seen);
        #1;
        seen = core_req;
        for (int n = 0; n < 16 && !seen; n++) begin
            @(negedge clk);
            #1;
            seen = core_req;
        end
        if (!seen) begin
            n_fail++;
            $display("Error at %0t: core_req did not rise within 16 cycles", $time);
        end
    endtask

    // Target model stalls, accepts, then returns bl+1 beats with the last marked
    task automatic serve_burst(input int unsigned idx, input int unsigned stall, input bit keep);
        logic [dwidth-1:0] beat_data;
        logic [dwidth-1:0] exp_rd;
        bit                seen;
        wait_core_req(seen);
        if (!seen) return;
        check_req("core payload", core_payload(), pl[idx]);
        repeat (stall) begin
            @(negedge clk);
            #1;
            check_req("payload under stall", core_payload(), pl[idx]);
            check_data("req_ack under stall", dwidth'(req_ack), '0);
        end
        @(negedge clk);
        core_req_ack = 1'b1;
        #1;
        check_idx("granted requester", ack_owner(), req_idx_t'(idx));
        check_data("req_ack vector", dwidth'(req_ack), dwidth'(1) << idx);
        for (int b = 0; b <= int'(pl[idx].bl); b++) begin
            @(negedge clk);
            core_req_ack = 1'b0;
            if (!keep) req[idx] = 1'b0;
            beat_data  = $random(seed);
            core_rdata = beat_data;
            core_resp  = (b == int'(pl[idx].bl)) ? resp_rdy_lok : resp_rdy_ok;
            #1;
            // Last beat reads as rdy_ok since bit 1 is cleared toward requesters
            check_resp("resp to requester", mem_resp_e'(resp[idx]), resp_rdy_ok);
            check_data("resp vector", dwidth'(resp), dwidth'(1) << (2 * idx));
            check_data("lack vector", dwidth'(lack),
                       (b == int'(pl[idx].bl)) ? dwidth'(1) << idx : '0);
            for (int i = 0; i < n_req; i++) begin
                exp_rd = (i == int'(idx)) ? beat_data : '0;
                check_data("rdata routing", rdata[i], exp_rd);
            end
        end
        @(negedge clk);
        core_resp  = resp_notrdy;
        core_rdata = '0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic idle_after_reset();
        do_reset();
        repeat (3) @(negedge clk);
        #1;
        check_data("core_req idle", dwidth'(core_req), '0);
        check_data("req_ack idle", dwidth'(req_ack), '0);
        check_data("lack idle", dwidth'(lack), '0);
        check_data("resp idle", dwidth'(resp), '0);
        check_req("core payload idle", core_payload(), '0);
        report_test("reset_idle");
    endtask

    task automatic tid_filtering();
        new_payload(1, 1'b0);
        @(negedge clk);
        drive_req(1, target_id ^ 3'd2);
        repeat (6) begin
            @(negedge clk);
            #1;
            check_data("core_req on tid miss", dwidth'(core_req), '0);
        end
        @(negedge clk);
        tid[1] = target_id;
        serve_burst(1, 0, 1'b0);
        report_test("tid_filter");
    endtask

    task automatic single_read_burst();
        new_payload(2, 1'b0);
        @(negedge clk);
        drive_req(2, target_id);
        serve_burst(2, 0, 1'b0);
        report_test("read_burst");
    endtask

    // All four keep requesting from a fresh pointer
    task automatic grant_rotation();
        do_reset();
        for (int i = 0; i < n_req; i++) begin
            new_payload(i, 1'b0);
            drive_req(i, target_id);
        end
        for (int k = 0; k <= n_req; k++) begin
            serve_burst(k % n_req, 0, 1'b1);
        end
        req = '0;
        report_test("rr_order");
    endtask

    // Requester 3 arrives while requester 0 is stalled
    task automatic stall_holds_grant();
        bit seen;
        new_payload(0, 1'b0);
        new_payload(3, 1'b1);
        @(negedge clk);
        drive_req(0, target_id);
        wait_core_req(seen);
        @(negedge clk);
        drive_req(3, target_id);
        serve_burst(0, 4, 1'b0);
        serve_burst(3, 0, 1'b0);
        report_test("backpressure");
    endtask

    task automatic write_bursts();
        for (int i = 1; i < 3; i++) begin
            new_payload(i, 1'b1);
            @(negedge clk);
            drive_req(i, target_id);
            serve_burst(i, 1, 1'b0);
        end
        report_test("write_burst");
    endtask

    initial begin
        seed         = 32'ha6f4;
        n_pass       = 0;
        n_fail       = 0;
        n_tests      = 0;
        fail_mark    = 0;
        target_id    = 3'd5;
        tid          = '0;
        cmd          = '0;
        width        = '0;
        addr         = '0;
        bl           = '0;
        wdata        = '0;
        idle_after_reset();
        tid_filtering();
        single_read_burst();
        grant_rotation();
        stall_holds_grant();
        write_bursts();
        $display("Summary: %0d tests, %0d checks passed, %0d checks failed",
                 n_tests, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(limit_time);
        $display("Error: watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_ycr_mem_router

`default_nettype wire

/* flist.f */
logic/ycr_router_pkg.sv
logic/router_grant_if.sv
logic/router_rr_pointer.sv
logic/router_arb_fsm.sv
logic/router_req_select.sv
logic/router_resp_route.sv
logic/ycr_mem_router.sv
dv/router_assert.sv
dv/tb_ycr_mem_router.sv

/* run.sh */
#!/bin/sh
# Build and run the memory router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_ycr_mem_router \
    -Mdir obj_dir -o sim_router > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_router > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0
